// ==== verilog.f ====
rtl/cpu_types_pkg.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/decode_unit.sv
rtl/dc_ex.sv
rtl/execute_unit.sv
rtl/mem_arbiter.sv
rtl/cpu_top.sv
bench/cpu_chk.sv
bench/cpu_tb.sv

// ==== bench/cpu_tb.sv ====
module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_WORDS = 256;
  localparam int HALT_LIMIT = 3000;
  localparam int MODEL_STEPS = 5000;

  logic CLK;
  logic nRST;
  logic run;
  logic host_en;
  logic host_wen;
  cpu_types_pkg::word_t host_addr;
  cpu_types_pkg::word_t host_wdata;
  cpu_types_pkg::word_t host_rdata;
  logic halt;

  cpu_types_pkg::word_t image [MEM_WORDS];  // what the host loads
  cpu_types_pkg::word_t model_mem [MEM_WORDS];
  cpu_types_pkg::word_t model_regs [32];  // carried across programs like the register file
  cpu_types_pkg::word_t prog [$];
  int seed;

  cpu_top #(.MEM_WORDS(MEM_WORDS)) DUT (.*);

  initial begin
    CLK = 1'b1;
    forever #10 CLK = ~CLK;
  end

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped after the first error");
  endtask

  always @(negedge CLK) begin
    if (DUT.u_dc_ex.u_chk.fail_count != 0) begin
      $display("a dc_ex assertion failed");
      stop_run();
    end
  end

  task automatic asm_r(input int funct, input int rd, input int rs, input int rt,
                       input int shamt = 0);
    prog.push_back({6'h00, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct[5:0]});
  endtask

  // operand order follows the assembler, rt first
  task automatic asm_i(input int op, input int rt, input int rs, input int imm);
    prog.push_back({op[5:0], rs[4:0], rt[4:0], imm[15:0]});
  endtask

  task automatic asm_j(input int word_addr);
    prog.push_back({cpu_types_pkg::OP_J, word_addr[25:0]});
  endtask

  task automatic asm_halt();
    prog.push_back({cpu_types_pkg::OP_HALT, 26'd0});
  endtask

  task automatic place_program();
    int a;
    for (a = 0; a < MEM_WORDS; a++)
      image[a] = 32'hf111_0000 + a;  // opcode 6'h3c decodes to nothing
    for (a = 0; a < prog.size(); a++)
      image[a] = prog[a];
  endtask

  // instruction-set model of the program, no pipeline
  function automatic bit run_model();
    cpu_types_pkg::word_t pc, ir, a, b, ext, ea, res;
    logic [4:0] dst;
    int step;
    pc = '0;
    for (step = 0; step < MODEL_STEPS; step++) begin
      ir = model_mem[pc[9:2]];
      pc = pc + 32'd4;
      a = model_regs[ir[25:21]];
      b = model_regs[ir[20:16]];
      ext = {{16{ir[15]}}, ir[15:0]};
      ea = a + ext;
      dst = ir[20:16];
      res = '0;
      case (ir[31:26])
        cpu_types_pkg::OP_HALT: return 1'b1;
        cpu_types_pkg::OP_RTYPE: begin
          dst = ir[15:11];
          case (ir[5:0])
            cpu_types_pkg::ADDU: res = a + b;
            cpu_types_pkg::SUBU: res = a - b;
            cpu_types_pkg::AND: res = a & b;
            cpu_types_pkg::OR: res = a | b;
            cpu_types_pkg::SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_types_pkg::SLL: res = b << ir[10:6];
            default: dst = '0;
          endcase
        end
        cpu_types_pkg::OP_ADDIU: res = ea;
        cpu_types_pkg::OP_ORI: res = a | {16'h0000, ir[15:0]};
        cpu_types_pkg::OP_LUI: res = {ir[15:0], 16'h0000};
        cpu_types_pkg::OP_LW: res = model_mem[ea[9:2]];
        default: begin
          dst = '0;
          if (ir[31:26] == cpu_types_pkg::OP_SW) model_mem[ea[9:2]] = b;
          if (ir[31:26] == cpu_types_pkg::OP_BEQ && a == b) pc = pc + (ext << 2);
          if (ir[31:26] == cpu_types_pkg::OP_BNE && a != b) pc = pc + (ext << 2);
          if (ir[31:26] == cpu_types_pkg::OP_J) pc = {pc[31:28], ir[25:0], 2'b00};
        end
      endcase
      if (dst != '0) model_regs[dst] = res;
    end
    return 1'b0;
  endfunction

  task automatic host_write(input int a, input cpu_types_pkg::word_t d);
    @(negedge CLK);
    host_en = 1'b1;
    host_wen = 1'b1;
    host_addr = a << 2;
    host_wdata = d;
  endtask

  task automatic host_read(input int a, output cpu_types_pkg::word_t d);
    @(negedge CLK);
    host_en = 1'b1;
    host_wen = 1'b0;
    host_addr = a << 2;
    @(negedge CLK);
    d = host_rdata;  // registered read, valid one cycle after host_en
    host_en = 1'b0;
  endtask

  task automatic load_image();
    int a;
    for (a = 0; a < MEM_WORDS; a++)
      host_write(a, image[a]);
    @(negedge CLK);
    host_en = 1'b0;
    host_wen = 1'b0;
  endtask

  task automatic compare_memory(input bit against_image);
    cpu_types_pkg::word_t got, exp;
    int a;
    for (a = 0; a < MEM_WORDS; a++) begin
      host_read(a, got);
      exp = against_image ? image[a] : model_mem[a];
      assert (got === exp) else begin
        $display("Fail host_rdata addr %h: expected %h, got %h", a << 2, exp, got);
        stop_run();
      end
    end
    assert (!halt) else begin
      $display("halt was high while the core was idle");
      stop_run();
    end
  endtask

  task automatic run_program();
    int cycles;
    @(negedge CLK);
    run = 1'b1;
    cycles = 0;
    while (!halt && cycles < HALT_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    assert (halt) else begin
      $display("halt did not rise within %0d cycles", HALT_LIMIT);
      stop_run();
    end
    repeat (8) begin
      @(negedge CLK);
      assert (halt) else begin
        $display("halt fell while run was still high");
        stop_run();
      end
    end
    run = 1'b0;
  endtask

  task automatic check_program();
    bit ok;
    model_mem = image;
    ok = run_model();
    assert (ok) else begin
      $display("reference model did not reach HALT");
      stop_run();
    end
    run_program();
    compare_memory(1'b0);
  endtask

  task automatic build_first_program();
    int loop_at;
    prog.delete();
    asm_i(cpu_types_pkg::OP_ADDIU, 1, 0, 32'h200);  // data base, word 128
    asm_i(cpu_types_pkg::OP_ADDIU, 2, 0, -7);
    asm_i(cpu_types_pkg::OP_ORI, 3, 0, 32'h8421);
    asm_i(cpu_types_pkg::OP_LUI, 4, 0, 32'h8000);
    asm_r(cpu_types_pkg::ADDU, 5, 2, 3);
    asm_r(cpu_types_pkg::SUBU, 6, 2, 3);
    asm_r(cpu_types_pkg::AND, 7, 3, 2);
    asm_r(cpu_types_pkg::OR, 8, 2, 4);
    asm_r(cpu_types_pkg::SLT, 9, 2, 3);
    asm_r(cpu_types_pkg::SLT, 10, 3, 2);
    asm_r(cpu_types_pkg::SLT, 11, 4, 2);
    asm_r(cpu_types_pkg::SLL, 12, 0, 3, 7);
    asm_i(cpu_types_pkg::OP_LUI, 13, 0, 32'h1234);
    asm_i(cpu_types_pkg::OP_ORI, 13, 13, 32'h5678);
    for (int r = 5; r <= 13; r++)
      asm_i(cpu_types_pkg::OP_SW, r, 1, (r - 5) * 4);
    asm_i(cpu_types_pkg::OP_ADDIU, 14, 0, 3);  // each step needs the one before
    asm_r(cpu_types_pkg::ADDU, 14, 14, 14);
    asm_r(cpu_types_pkg::SUBU, 14, 14, 2);
    asm_r(cpu_types_pkg::SLL, 14, 0, 14, 2);
    asm_i(cpu_types_pkg::OP_SW, 14, 1, 36);
    asm_i(cpu_types_pkg::OP_LW, 15, 1, 0);
    asm_r(cpu_types_pkg::ADDU, 16, 15, 15);
    asm_i(cpu_types_pkg::OP_SW, 16, 1, 40);
    asm_i(cpu_types_pkg::OP_LW, 17, 1, 36);
    asm_i(cpu_types_pkg::OP_SW, 17, 1, 44);
    asm_i(cpu_types_pkg::OP_BEQ, 3, 2, 1);  // not taken
    asm_i(cpu_types_pkg::OP_ADDIU, 18, 0, 32'h11);
    asm_i(cpu_types_pkg::OP_SW, 18, 1, 48);
    asm_i(cpu_types_pkg::OP_BNE, 3, 2, 1);
    asm_i(cpu_types_pkg::OP_SW, 2, 1, 52);  // skipped
    asm_i(cpu_types_pkg::OP_BEQ, 2, 2, 1);
    asm_i(cpu_types_pkg::OP_SW, 2, 1, 56);  // skipped
    asm_i(cpu_types_pkg::OP_BNE, 3, 3, 1);  // not taken
    asm_i(cpu_types_pkg::OP_SW, 3, 1, 60);
    asm_j(prog.size() + 3);
    asm_i(cpu_types_pkg::OP_SW, 2, 1, 64);  // skipped by the jump
    asm_i(cpu_types_pkg::OP_SW, 2, 1, 68);
    asm_i(cpu_types_pkg::OP_SW, 4, 1, 72);
    asm_i(cpu_types_pkg::OP_ADDIU, 19, 0, 4);
    asm_i(cpu_types_pkg::OP_ADDIU, 20, 0, 0);
    loop_at = prog.size();
    asm_r(cpu_types_pkg::ADDU, 20, 20, 19);
    asm_i(cpu_types_pkg::OP_ADDIU, 19, 19, -1);
    asm_i(cpu_types_pkg::OP_BNE, 0, 19, loop_at - prog.size() - 1);  // backward branch
    asm_i(cpu_types_pkg::OP_SW, 20, 1, 76);
    asm_halt();
    place_program();
  endtask

  task automatic build_random_program();
    int imm_a;
    int imm_b;
    int r;
    imm_a = $random(seed);
    imm_b = $random(seed);
    prog.delete();
    asm_i(cpu_types_pkg::OP_ADDIU, 1, 0, 32'h280);  // operands at word 160
    asm_i(cpu_types_pkg::OP_LW, 2, 1, 0);
    asm_i(cpu_types_pkg::OP_LW, 3, 1, 4);
    asm_i(cpu_types_pkg::OP_LW, 4, 1, 8);
    asm_r(cpu_types_pkg::ADDU, 5, 2, 3);
    asm_r(cpu_types_pkg::SUBU, 6, 3, 4);
    asm_r(cpu_types_pkg::AND, 7, 2, 4);
    asm_r(cpu_types_pkg::OR, 8, 3, 4);
    asm_r(cpu_types_pkg::SLT, 9, 2, 3);
    asm_r(cpu_types_pkg::SLT, 10, 4, 2);
    asm_r(cpu_types_pkg::SLL, 11, 0, 4, imm_a);
    asm_i(cpu_types_pkg::OP_ADDIU, 12, 2, imm_a);
    asm_i(cpu_types_pkg::OP_ORI, 13, 3, imm_b);
    for (r = 5; r <= 13; r++)
      asm_i(cpu_types_pkg::OP_SW, r, 1, 32'h40 + (r - 5) * 4);
    asm_halt();
    place_program();
    for (r = 0; r < 3; r++)
      image[160 + r] = $random(seed);
  endtask

  initial begin
    seed = 32'hd4f4;
    nRST = 1'b1;
    run = 1'b0;
    host_en = 1'b0;
    host_wen = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    foreach (model_regs[k])
      model_regs[k] = '0;
    @(negedge CLK);
    nRST = 1'b0;
    repeat (16) @(negedge CLK);
    nRST = 1'b1;

    build_first_program();
    load_image();
    compare_memory(1'b1);  // host round trip before anything runs
    check_program();
    repeat (3) begin
      build_random_program();
      load_image();
      check_program();  // restarts from PC 0 each time
    end

    if (DUT.u_dc_ex.u_chk.fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("dc_ex assertions failed %0d times", DUT.u_dc_ex.u_chk.fail_count);
      stop_run();
    end
  end

endmodule

// ==== bench/cpu_chk.sv ====
module dc_ex_chk (
  input logic CLK,
  input logic nRST,
  input logic pipe_en,
  input logic flush,
  input cpu_types_pkg::word_t npc_e, ext32_e, rdat1_e, rdat2_e,
  input logic [25:0] j_addr26_e,
  input logic [4:0] shamt_e,
  input cpu_types_pkg::alu_op_t alu_op_e,
  input cpu_types_pkg::alu_src_t alu_src_e,
  input cpu_types_pkg::pc_src_t pc_src_e,
  input logic d_ren_e, d_wen_e, wen_e, halt_e,
  input cpu_types_pkg::regsel_t wsel_e
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // polled by the testbench
  logic ctrl_active;

  assign ctrl_active = wen_e || d_ren_e || d_wen_e || halt_e;

  flush_gives_bubble: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !ctrl_active)
    else begin
      fail_count = fail_count + 1;
      $error("dc_ex control still active in the cycle after a flush");
    end

  hold_without_enable: assert property (@(posedge CLK) disable iff (!nRST)
    !pipe_en && !flush |=> $stable({npc_e, ext32_e, j_addr26_e, shamt_e, alu_op_e,
      alu_src_e, pc_src_e, d_ren_e, d_wen_e, wen_e, wsel_e, halt_e, rdat1_e, rdat2_e}))
    else begin
      fail_count = fail_count + 1;
      $error("dc_ex outputs changed while pipe_en was low");
    end

  // selects must sit at their bubble values too, not only the enables
  quiet_in_reset: assert property (@(posedge CLK)
    !nRST |-> !ctrl_active && wsel_e == '0 && alu_op_e == cpu_types_pkg::ALU_SLL
      && alu_src_e == cpu_types_pkg::SRC_RDAT2 && pc_src_e == cpu_types_pkg::PC_ADD4)
    else begin
      fail_count = fail_count + 1;
      $error("dc_ex control output active during reset");
    end

endmodule

bind dc_ex dc_ex_chk u_chk (.*);

// ==== rtl/cpu_top.sv ====
module cpu_top #(
  parameter int MEM_WORDS = 256
) (
  input logic CLK,
  input logic nRST,
  input logic run,
  input logic host_en,
  input logic host_wen,
  input cpu_types_pkg::word_t host_addr,
  input cpu_types_pkg::word_t host_wdata,
  output cpu_types_pkg::word_t host_rdata,
  output logic halt
);
  cpu_types_pkg::instr_t instr;
  cpu_types_pkg::word_t npc, target, i_addr, i_rdata, d_addr, d_wdata, d_rdata, wb_wdat;
  cpu_types_pkg::word_t npc_d, npc_e, ext32_d, ext32_e;
  cpu_types_pkg::word_t rdat1_d, rdat1_e, rdat2_d, rdat2_e;
  cpu_types_pkg::regsel_t rsel1, rsel2, wsel_d, wsel_e, wb_wsel;
  cpu_types_pkg::alu_op_t alu_op_d, alu_op_e;
  cpu_types_pkg::alu_src_t alu_src_d, alu_src_e;
  cpu_types_pkg::pc_src_t pc_src_d, pc_src_e;
  logic [25:0] j_addr26_d, j_addr26_e;
  logic [4:0] shamt_d, shamt_e;
  logic valid, stall, ex_busy, redirect, wb_wen;
  logic i_req, i_gnt, d_req, d_wen, d_gnt;
  logic d_ren_d, d_ren_e, d_wen_d, d_wen_e, wen_d, wen_e, halt_d, halt_e;

  fetch_unit u_fetch (.*);

  register_file u_regs (
    .*,
    .rdat1(rdat1_d),
    .rdat2(rdat2_d),
    .wen(wb_wen),
    .wsel(wb_wsel),
    .wdat(wb_wdat)
  );

  decode_unit u_decode (.*, .ex_wen(wen_e), .ex_wsel(wsel_e));

  // a stalled decode sends a bubble only when execute can take it
  dc_ex u_dc_ex (
    .*,
    .pipe_en(!ex_busy),
    .flush(redirect || (stall && !ex_busy) || !run)
  );

  execute_unit u_execute (.*);

  mem_arbiter #(.MEM_WORDS(MEM_WORDS)) u_mem (.*);

endmodule

// ==== rtl/mem_arbiter.sv ====
module mem_arbiter #(
  parameter int MEM_WORDS = 256
) (
  input logic CLK,
  input logic nRST,
  input logic run,
  input logic host_en,
  input logic host_wen,
  input cpu_types_pkg::word_t host_addr,
  input cpu_types_pkg::word_t host_wdata,
  output cpu_types_pkg::word_t host_rdata,
  input logic i_req,
  input cpu_types_pkg::word_t i_addr,
  output logic i_gnt,
  output cpu_types_pkg::word_t i_rdata,
  input logic d_req,
  input logic d_wen,
  input cpu_types_pkg::word_t d_addr,
  input cpu_types_pkg::word_t d_wdata,
  output logic d_gnt,
  output cpu_types_pkg::word_t d_rdata
);
  localparam int AW = $clog2(MEM_WORDS);

  cpu_types_pkg::word_t mem [MEM_WORDS];
  cpu_types_pkg::word_t rdata_q;
  logic h_gnt;
  logic [2:0] gnt_q;  // host, data, fetch granted last cycle
  logic [AW-1:0] addr;

  assign h_gnt = !run && host_en;
  assign d_gnt = run && d_req;
  assign i_gnt = run && i_req && !d_req;

  // all three ports carry byte addresses of aligned words
  assign addr = h_gnt ? host_addr[AW+1:2] : d_gnt ? d_addr[AW+1:2] : i_addr[AW+1:2];

  always_ff @(posedge CLK) begin
    if (h_gnt || d_gnt || i_gnt) begin
      if (h_gnt ? host_wen : d_gnt && d_wen) mem[addr] <= h_gnt ? host_wdata : d_wdata;
      rdata_q <= mem[addr];
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) gnt_q <= '0;
    else gnt_q <= {h_gnt, d_gnt, i_gnt};
  end

  assign host_rdata = gnt_q[2] ? rdata_q : '0;
  assign d_rdata = gnt_q[1] ? rdata_q : '0;
  assign i_rdata = gnt_q[0] ? rdata_q : '0;

endmodule

// ==== rtl/execute_unit.sv ====
module execute_unit (
  input logic CLK,
  input logic nRST,
  input logic run,
  input cpu_types_pkg::word_t npc_e,
  input cpu_types_pkg::word_t ext32_e,
  input logic [25:0] j_addr26_e,
  input logic [4:0] shamt_e,
  input cpu_types_pkg::alu_op_t alu_op_e,
  input cpu_types_pkg::alu_src_t alu_src_e,
  input cpu_types_pkg::pc_src_t pc_src_e,
  input logic d_ren_e,
  input logic d_wen_e,
  input logic wen_e,
  input cpu_types_pkg::regsel_t wsel_e,
  input logic halt_e,
  input cpu_types_pkg::word_t rdat1_e,
  input cpu_types_pkg::word_t rdat2_e,
  output logic d_req,
  output logic d_wen,
  output cpu_types_pkg::word_t d_addr,
  output cpu_types_pkg::word_t d_wdata,
  input logic d_gnt,
  input cpu_types_pkg::word_t d_rdata,
  output logic wb_wen,
  output cpu_types_pkg::regsel_t wb_wsel,
  output cpu_types_pkg::word_t wb_wdat,
  output logic redirect,
  output cpu_types_pkg::word_t target,
  output logic ex_busy,
  output logic halt
);
  cpu_types_pkg::word_t b;
  cpu_types_pkg::word_t alu_out;
  logic load_wait;  // load granted last cycle, its data is on d_rdata
  logic taken;

  assign b = (alu_src_e == cpu_types_pkg::SRC_EXT32) ? ext32_e : rdat2_e;

  always_comb begin
    case (alu_op_e)
      cpu_types_pkg::ALU_ADD: alu_out = rdat1_e + b;
      cpu_types_pkg::ALU_SUB: alu_out = rdat1_e - b;
      cpu_types_pkg::ALU_AND: alu_out = rdat1_e & b;
      cpu_types_pkg::ALU_OR: alu_out = rdat1_e | b;
      cpu_types_pkg::ALU_SLT: alu_out = {31'd0, $signed(rdat1_e) < $signed(b)};
      cpu_types_pkg::ALU_LUI: alu_out = {b[15:0], 16'h0000};
      default: alu_out = b << shamt_e;
    endcase
  end

  assign d_req = run && !load_wait && (d_ren_e || d_wen_e);
  assign d_wen = d_wen_e;
  assign d_addr = alu_out;
  assign d_wdata = rdat2_e;
  // halt_e keeps dc_ex frozen on the HALT until run drops
  assign ex_busy = halt_e || (d_req && (d_ren_e || !d_gnt));

  assign wb_wen = run && wen_e && (!d_ren_e || load_wait);
  assign wb_wsel = wsel_e;
  assign wb_wdat = d_ren_e ? d_rdata : alu_out;

  assign taken = (pc_src_e == cpu_types_pkg::PC_BEQ && rdat1_e == rdat2_e)
              || (pc_src_e == cpu_types_pkg::PC_BNE && rdat1_e != rdat2_e);
  assign redirect = run && (taken || pc_src_e == cpu_types_pkg::PC_JUMP);
  assign target = (pc_src_e == cpu_types_pkg::PC_JUMP) ? {npc_e[31:28], j_addr26_e, 2'b00}
                                                       : npc_e + {ext32_e[29:0], 2'b00};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      load_wait <= 1'b0;
      halt <= 1'b0;
    end else if (!run) begin
      load_wait <= 1'b0;
      halt <= 1'b0;
    end else begin
      load_wait <= d_req && d_ren_e && d_gnt;
      if (halt_e) halt <= 1'b1;
    end
  end

endmodule

// ==== rtl/dc_ex.sv ====
module dc_ex (
  input logic CLK,
  input logic nRST,
  input logic pipe_en,
  input logic flush,
  input cpu_types_pkg::word_t npc_d,
  input cpu_types_pkg::word_t ext32_d,
  input logic [25:0] j_addr26_d,
  input logic [4:0] shamt_d,
  input cpu_types_pkg::alu_op_t alu_op_d,
  input cpu_types_pkg::alu_src_t alu_src_d,
  input cpu_types_pkg::pc_src_t pc_src_d,
  input logic d_ren_d,
  input logic d_wen_d,
  input logic wen_d,
  input cpu_types_pkg::regsel_t wsel_d,
  input logic halt_d,
  input cpu_types_pkg::word_t rdat1_d,
  input cpu_types_pkg::word_t rdat2_d,
  output cpu_types_pkg::word_t npc_e,
  output cpu_types_pkg::word_t ext32_e,
  output logic [25:0] j_addr26_e,
  output logic [4:0] shamt_e,
  output cpu_types_pkg::alu_op_t alu_op_e,
  output cpu_types_pkg::alu_src_t alu_src_e,
  output cpu_types_pkg::pc_src_t pc_src_e,
  output logic d_ren_e,
  output logic d_wen_e,
  output logic wen_e,
  output cpu_types_pkg::regsel_t wsel_e,
  output logic halt_e,
  output cpu_types_pkg::word_t rdat1_e,
  output cpu_types_pkg::word_t rdat2_e
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      alu_op_e <= cpu_types_pkg::ALU_SLL;
      alu_src_e <= cpu_types_pkg::SRC_RDAT2;
      pc_src_e <= cpu_types_pkg::PC_ADD4;
      {d_ren_e, d_wen_e, wen_e, halt_e} <= '0;
      wsel_e <= '0;
    end else if (flush) begin
      alu_op_e <= cpu_types_pkg::ALU_SLL;  // bubble
      alu_src_e <= cpu_types_pkg::SRC_RDAT2;
      pc_src_e <= cpu_types_pkg::PC_ADD4;
      {d_ren_e, d_wen_e, wen_e, halt_e} <= '0;
      wsel_e <= '0;
    end else if (pipe_en) begin
      alu_op_e <= alu_op_d;
      alu_src_e <= alu_src_d;
      pc_src_e <= pc_src_d;
      {d_ren_e, d_wen_e, wen_e, halt_e} <= {d_ren_d, d_wen_d, wen_d, halt_d};
      wsel_e <= wsel_d;
    end
  end

  // operands follow the controls, a bubble leaves them meaningless
  always_ff @(posedge CLK) begin
    if (pipe_en) begin
      npc_e <= npc_d;
      ext32_e <= ext32_d;
      j_addr26_e <= j_addr26_d;
      shamt_e <= shamt_d;
      rdat1_e <= rdat1_d;
      rdat2_e <= rdat2_d;
    end
  end

endmodule

// ==== rtl/decode_unit.sv ====
module decode_unit (
  input cpu_types_pkg::instr_t instr,
  input cpu_types_pkg::word_t npc,
  input logic valid,
  input logic ex_wen,
  input cpu_types_pkg::regsel_t ex_wsel,
  output cpu_types_pkg::regsel_t rsel1,
  output cpu_types_pkg::regsel_t rsel2,
  output logic stall,
  output cpu_types_pkg::word_t npc_d,
  output cpu_types_pkg::word_t ext32_d,
  output logic [25:0] j_addr26_d,
  output logic [4:0] shamt_d,
  output cpu_types_pkg::alu_op_t alu_op_d,
  output cpu_types_pkg::alu_src_t alu_src_d,
  output cpu_types_pkg::pc_src_t pc_src_d,
  output logic d_ren_d,
  output logic d_wen_d,
  output logic wen_d,
  output cpu_types_pkg::regsel_t wsel_d,
  output logic halt_d
);
  logic use_rs;
  logic use_rt;

  always_comb begin
    npc_d = '0;
    ext32_d = '0;
    j_addr26_d = '0;
    shamt_d = '0;
    alu_op_d = cpu_types_pkg::ALU_SLL;
    alu_src_d = cpu_types_pkg::SRC_RDAT2;
    pc_src_d = cpu_types_pkg::PC_ADD4;
    d_ren_d = 1'b0;
    d_wen_d = 1'b0;
    wen_d = 1'b0;
    wsel_d = '0;
    halt_d = 1'b0;
    use_rs = 1'b0;
    use_rt = 1'b0;
    if (valid) begin
      npc_d = npc;
      ext32_d = {{16{instr.i.imm16[15]}}, instr.i.imm16};
      j_addr26_d = instr.j.addr26;
      shamt_d = instr.r.shamt;
      wsel_d = instr.i.rt;
      use_rs = 1'b1;
      case (instr.r.opcode)
        cpu_types_pkg::OP_RTYPE: begin
          use_rt = 1'b1;
          wen_d = 1'b1;
          wsel_d = instr.r.rd;
          case (instr.r.funct)
            cpu_types_pkg::ADDU: alu_op_d = cpu_types_pkg::ALU_ADD;
            cpu_types_pkg::SUBU: alu_op_d = cpu_types_pkg::ALU_SUB;
            cpu_types_pkg::AND: alu_op_d = cpu_types_pkg::ALU_AND;
            cpu_types_pkg::OR: alu_op_d = cpu_types_pkg::ALU_OR;
            cpu_types_pkg::SLT: alu_op_d = cpu_types_pkg::ALU_SLT;
            cpu_types_pkg::SLL: use_rs = 1'b0;  // shifts rt only
            default: wen_d = 1'b0;
          endcase
        end
        cpu_types_pkg::OP_ADDIU, cpu_types_pkg::OP_LW: begin
          alu_op_d = cpu_types_pkg::ALU_ADD;
          alu_src_d = cpu_types_pkg::SRC_EXT32;
          wen_d = 1'b1;
          d_ren_d = (instr.i.opcode == cpu_types_pkg::OP_LW);
        end
        cpu_types_pkg::OP_ORI: begin
          alu_op_d = cpu_types_pkg::ALU_OR;
          alu_src_d = cpu_types_pkg::SRC_EXT32;
          ext32_d = {16'h0000, instr.i.imm16};
          wen_d = 1'b1;
        end
        cpu_types_pkg::OP_LUI: begin
          alu_op_d = cpu_types_pkg::ALU_LUI;
          alu_src_d = cpu_types_pkg::SRC_EXT32;
          wen_d = 1'b1;
          use_rs = 1'b0;
        end
        cpu_types_pkg::OP_SW: begin
          alu_op_d = cpu_types_pkg::ALU_ADD;
          alu_src_d = cpu_types_pkg::SRC_EXT32;
          d_wen_d = 1'b1;
          use_rt = 1'b1;
        end
        cpu_types_pkg::OP_BEQ: begin
          pc_src_d = cpu_types_pkg::PC_BEQ;
          use_rt = 1'b1;
        end
        cpu_types_pkg::OP_BNE: begin
          pc_src_d = cpu_types_pkg::PC_BNE;
          use_rt = 1'b1;
        end
        cpu_types_pkg::OP_J: begin
          pc_src_d = cpu_types_pkg::PC_JUMP;
          use_rs = 1'b0;
        end
        cpu_types_pkg::OP_HALT: begin
          halt_d = 1'b1;
          use_rs = 1'b0;
        end
        default: use_rs = 1'b0;
      endcase
    end
  end

  // unused sources read r0, which never matches a nonzero ex_wsel
  assign rsel1 = use_rs ? instr.r.rs : '0;
  assign rsel2 = use_rt ? instr.r.rt : '0;
  assign stall = ex_wen && ex_wsel != '0 && (ex_wsel == rsel1 || ex_wsel == rsel2);

endmodule

// ==== rtl/register_file.sv ====
module register_file (
  input logic CLK,
  input logic nRST,
  input cpu_types_pkg::regsel_t rsel1,
  input cpu_types_pkg::regsel_t rsel2,
  output cpu_types_pkg::word_t rdat1,
  output cpu_types_pkg::word_t rdat2,
  input logic wen,
  input cpu_types_pkg::regsel_t wsel,
  input cpu_types_pkg::word_t wdat
);
  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  always_comb begin
    rdat1 = regs[rsel1];
    rdat2 = regs[rsel2];
    if (wen && wsel == rsel1) rdat1 = wdat;  // writeback seen in the same cycle
    if (wen && wsel == rsel2) rdat2 = wdat;
    if (rsel1 == '0) rdat1 = '0;
    if (rsel2 == '0) rdat2 = '0;
  end

endmodule

// ==== rtl/fetch_unit.sv ====
module fetch_unit (
  input logic CLK,
  input logic nRST,
  input logic run,
  input logic stall,
  input logic ex_busy,
  input logic redirect,
  input cpu_types_pkg::word_t target,
  output logic i_req,
  output cpu_types_pkg::word_t i_addr,
  input logic i_gnt,
  input cpu_types_pkg::word_t i_rdata,
  output cpu_types_pkg::instr_t instr,
  output cpu_types_pkg::word_t npc,
  output logic valid
);
  cpu_types_pkg::word_t pc;
  logic pending;
  logic hold;

  assign hold = valid && (stall || ex_busy);  // decode keeps its instruction this cycle
  assign i_req = run && !redirect && !pending && !hold;
  assign i_addr = pc;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= '0;
      pending <= 1'b0;
      valid <= 1'b0;
    end else if (!run) begin
      pc <= '0;
      pending <= 1'b0;
      valid <= 1'b0;
    end else if (redirect) begin
      pc <= target;  // the word in flight is dropped with pending
      pending <= 1'b0;
      valid <= 1'b0;
    end else begin
      pending <= i_gnt;
      if (i_gnt) pc <= pc + 32'd4;
      if (pending) valid <= 1'b1;
      else if (!hold) valid <= 1'b0;
    end
  end

  // pc already points past the returning word, so it is the npc
  always_ff @(posedge CLK) begin
    if (pending && !redirect) begin
      instr <= i_rdata;
      npc <= pc;
    end
  end

endmodule

// ==== rtl/cpu_types_pkg.sv ====
package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regsel_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f
  } opcode_t;

  typedef enum logic [5:0] {
    SLL  = 6'h00,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI
  } alu_op_t;

  typedef enum logic {SRC_RDAT2, SRC_EXT32} alu_src_t;

  typedef enum logic [1:0] {PC_ADD4, PC_BEQ, PC_BNE, PC_JUMP} pc_src_t;

  // one fetched word seen through the three MIPS encodings
  typedef union packed {
    struct packed {
      opcode_t opcode;
      regsel_t rs;
      regsel_t rt;
      regsel_t rd;
      logic [4:0] shamt;
      funct_t funct;
    } r;
    struct packed {
      opcode_t opcode;
      regsel_t rs;
      regsel_t rt;
      logic [15:0] imm16;
    } i;
    struct packed {
      opcode_t opcode;
      logic [25:0] addr26;
    } j;
  } instr_t;

endpackage
